// File: raster_decode.sv
/*
	decode stage of the raster pipeline
	takes the command handshake, splits command and mode words into fields
	works out the active flag, one entry output register
*/
`timescale 1ns/1ns

module raster_decode (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,
	input  raster_pkg::cmd_word_t  cmd_word,
	input  raster_pkg::mode_word_t mode_word,
	input  raster_pkg::ram_word_t  ram_data,
	raster_cmd_if.decode           cmd
);
	import raster_pkg::*;

	logic accept;   // command taken this edge
	logic win_bit;  // pixel inside display window
	logic on_bit;   // raster switched on for this line

	// ********************
	// handshake
	// ********************
	assign win_bit   = cmd_word[CMD_WIN_BIT];
	assign on_bit    = mode_word[MODE_ON_BIT];
	assign cmd_ready = !cmd.valid || cmd.ready;  // empty, or draining this cycle
	assign accept    = cmd_valid && cmd_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd.valid <= 1'b0;
		end else if (cmd_ready) begin
			cmd.valid <= cmd_valid;  // refill or go empty
		end
	end

	// ********************
	// field split
	// ********************
	// payload only, valid above qualifies it
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd.mode   <= mode_word[MODE_LSB +: MODE_W];
			cmd.active <= win_bit && on_bit;  // the single place this is decided
			cmd.xsub   <= cmd_word[CMD_X_LSB +: XSUB_W];
			cmd.bg     <= mode_word[MODE_BG_LSB +: COLOUR_W];
			cmd.fg     <= mode_word[MODE_FG_LSB +: COLOUR_W];
			cmd.font   <= cmd_word[CMD_FONT_LSB +: COLOUR_W];
			cmd.ram    <= ram_data;
			cmd.fmt565 <= mode_word[MODE_565_BIT];
		end
	end

	// ********************
	// checks
	// ********************
	// upstream must hold its command until it is taken
	property p_cmd_hold;
		@(posedge clk) disable iff (!rst_n)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable({cmd_word, mode_word, ram_data});
	endproperty

	a_cmd_hold: assert property (p_cmd_hold)
		else $error("cmd_valid or command data changed while stalled");

endmodule

// File: raster_expand.sv
/*
	expand stage of the raster pipeline
	picks pixel bits out of the ram word by colour mode
	builds the palette index or the true colour pixel, one entry register
*/
`timescale 1ns/1ns

module raster_expand (
	input  logic         clk,
	input  logic         rst_n,
	raster_cmd_if.expand cmd,
	raster_pix_if.expand pix
);
	import raster_pkg::*;

	logic       pix_free;  // output register empty or draining
	logic       accept;    // decoded command moves in
	logic       ram_bit;   // 1 bit slot, msb first
	logic [1:0] ram_pair;  // 2 bit slot
	logic [3:0] ram_nib;   // 4 bit slot
	colour_t    idx_nxt;
	pixel_t     dir_nxt;
	logic       true_nxt;

	// ********************
	// bit select
	// ********************
	// leftmost pixel lives in the top bits of the low byte
	assign ram_bit  = cmd.ram[~cmd.xsub];
	assign ram_pair = cmd.ram[{~cmd.xsub[2:1], 1'b0} +: 2];  // x 0 -> bits 7:6
	assign ram_nib  = cmd.ram[{~cmd.xsub[2], 2'b00} +: 4];   // x 0 -> bits 7:4

	// ********************
	// mode decode
	// ********************
	always_comb begin
		idx_nxt  = '0;  // inactive pixel gives index zero
		dir_nxt  = '0;
		true_nxt = 1'b0;
		if (cmd.active) begin
			case (cmd.mode)
				MODE_1BPP: begin
					idx_nxt = ram_bit ? cmd.fg : cmd.bg;
				end
				MODE_2BPP: begin
					idx_nxt = {cmd.bg[7:2], ram_pair};  // bank from bg
				end
				MODE_4BPP: begin
					idx_nxt = {cmd.bg[7:4], ram_nib};
				end
				MODE_8BPP: begin
					idx_nxt = cmd.ram[7:0];  // byte is the index
				end
				MODE_TXT8: begin
					// glyph bit picks fg or bg bank, font nibble fills the low half
					if (ram_bit) begin
						idx_nxt = {cmd.fg[7:4], cmd.font[7:4]};
					end else begin
						idx_nxt = {cmd.bg[7:4], cmd.font[3:0]};
					end
				end
				MODE_TXT4: begin
					idx_nxt = {cmd.font[7:2], ram_pair};  // bank from font colour
				end
				MODE_TXT2: begin
					idx_nxt = {cmd.font[7:4], ram_nib};
				end
				MODE_TRUE: begin
					true_nxt = 1'b1;     // palette bypass
					dir_nxt  = cmd.ram;  // word goes out untouched
				end
				default: begin
					idx_nxt = '0;
				end
			endcase
		end
	end

	// ********************
	// output register
	// ********************
	assign pix_free  = !pix.valid || pix.ready;
	assign cmd.ready = pix_free;
	assign accept    = cmd.valid && pix_free;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix.valid <= 1'b0;
		end else if (pix_free) begin
			pix.valid <= cmd.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pix.index   <= idx_nxt;
			pix.direct  <= dir_nxt;
			pix.is_true <= true_nxt;
			pix.window  <= cmd.active;  // inactive means blank downstream
			pix.fmt565  <= cmd.fmt565;
		end
	end

	// ********************
	// checks
	// ********************
	// a stalled pixel must not move under the result stage
	property p_pix_stable;
		@(posedge clk) disable iff (!rst_n)
		pix.valid && !pix.ready |=> pix.valid &&
			$stable({pix.index, pix.direct, pix.is_true, pix.window, pix.fmt565});
	endproperty

	a_pix_stable: assert property (p_pix_stable)
		else $error("pix data changed while stalled");

endmodule

// File: raster_if.sv
/*
	raster_cmd_if, decoded command from decode to expand
	raster_pix_if, expanded pixel from expand to result
*/
`timescale 1ns/1ns

// ********************
// decode -> expand
// ********************
interface raster_cmd_if;
	import raster_pkg::*;

	logic      valid;
	logic      ready;
	mode_t     mode;    // colour mode code
	logic      active;  // window bit and raster on
	xsub_t     xsub;    // pixel slot, x bits 2:0
	colour_t   bg;
	colour_t   fg;
	colour_t   font;
	ram_word_t ram;     // fetched video ram word
	logic      fmt565;

	modport decode (
		output valid, mode, active, xsub, bg, fg, font, ram, fmt565,
		input  ready
	);

	modport expand (
		input  valid, mode, active, xsub, bg, fg, font, ram, fmt565,
		output ready
	);

endinterface

// ********************
// expand -> result
// ********************
interface raster_pix_if;
	import raster_pkg::*;

	logic    valid;
	logic    ready;
	colour_t index;    // palette index
	pixel_t  direct;   // true colour pixel
	logic    is_true;  // use direct, skip the palette
	logic    window;   // low means blank
	logic    fmt565;

	modport expand (
		output valid, index, direct, is_true, window, fmt565,
		input  ready
	);

	modport result (
		input  valid, index, direct, is_true, window, fmt565,
		output ready
	);

endinterface

// File: raster_palette_out.sv
/*
	result stage of the raster pipeline
	writable 256 entry palette, true colour bypass, blanking outside the window
	drives the pixel handshake towards the dac
*/
`timescale 1ns/1ns

module raster_palette_out (
	input  logic                clk,
	input  logic                rst_n,
	raster_pix_if.result        pix,
	input  logic                pal_we,
	input  raster_pkg::colour_t pal_addr,
	input  raster_pkg::pixel_t  pal_data,
	output logic                pix_valid,
	input  logic                pix_ready,
	output raster_pkg::pixel_t  pix_data,
	output logic                pix_window,
	output logic                pix_565
);
	import raster_pkg::*;

	pixel_t  pal [PAL_DEPTH];  // palette entries
	logic    load;             // pixel moves into the output register
	colour_t idx_q;
	pixel_t  dir_q;
	logic    true_q;
	logic    win_q;
	logic    f565_q;
	pixel_t  lookup;           // palette or bypass, before blanking

	// ********************
	// palette
	// ********************
	// write takes effect for lookups after this edge
	always_ff @(posedge clk) begin
		if (pal_we) begin
			pal[pal_addr] <= pal_data;
		end
	end

	// ********************
	// output register
	// ********************
	assign pix.ready = !pix_valid || pix_ready;
	assign load      = pix.valid && pix.ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
			win_q     <= 1'b0;  // keeps pix_data at zero out of reset
			f565_q    <= 1'b0;
		end else begin
			if (pix.ready) begin
				pix_valid <= pix.valid;
			end
			if (load) begin
				win_q  <= pix.window;
				f565_q <= pix.fmt565;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			idx_q  <= pix.index;
			dir_q  <= pix.direct;
			true_q <= pix.is_true;
		end
	end

	assign lookup     = true_q ? dir_q : pal[idx_q];  // true colour skips the palette
	assign pix_data   = win_q ? lookup : '0;          // blank outside window
	assign pix_window = win_q;
	assign pix_565    = f565_q;

	// ********************
	// checks
	// ********************
	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown({pix_valid, pix_window}))
		else $error("pix_valid or pix_window unknown");

endmodule

// File: raster_pkg.sv
/*
	raster pipeline shared definitions
	field widths and vector typedefs
	command / mode word bit positions, colour mode codes, palette depth
*/
package raster_pkg;

	// ********************
	// widths
	// ********************
	localparam int COLOUR_W    = 8;   // palette index, bg / fg / font colour
	localparam int PIXEL_W     = 16;  // rgb565 or true colour pixel
	localparam int RAM_W       = 16;  // video ram word
	localparam int MODE_W      = 3;   // colour mode code
	localparam int XSUB_W      = 3;   // pixel slot inside a byte
	localparam int CMD_W       = 32;  // per-pixel command word
	localparam int MODE_WORD_W = 24;  // per-line mode / colour word

	typedef logic [COLOUR_W-1:0]    colour_t;
	typedef logic [PIXEL_W-1:0]     pixel_t;
	typedef logic [RAM_W-1:0]       ram_word_t;
	typedef logic [MODE_W-1:0]      mode_t;
	typedef logic [XSUB_W-1:0]      xsub_t;
	typedef logic [CMD_W-1:0]       cmd_word_t;
	typedef logic [MODE_WORD_W-1:0] mode_word_t;

	// ********************
	// colour modes
	// ********************
	// low three bits of the mode word, bit 3 turns the raster on
	localparam mode_t MODE_1BPP = 3'd0;  // 2 colours, 8 pixels per byte
	localparam mode_t MODE_2BPP = 3'd1;  // 4 colours, 4 pixels per byte
	localparam mode_t MODE_4BPP = 3'd2;  // 16 colours, 2 pixels per byte
	localparam mode_t MODE_8BPP = 3'd3;  // 256 colours, 1 pixel per byte
	localparam mode_t MODE_TXT8 = 3'd4;  // text, 8 pixels per word
	localparam mode_t MODE_TXT4 = 3'd5;  // text, 4 pixels per word
	localparam mode_t MODE_TXT2 = 3'd6;  // text, 2 pixels per word
	localparam mode_t MODE_TRUE = 3'd7;  // 16 bit true colour, palette bypassed

	// ********************
	// field positions
	// ********************
	// command word
	localparam int CMD_X_LSB    = 0;   // x position, only bits 2:0 matter here
	localparam int CMD_WIN_BIT  = 7;   // pixel inside display window
	localparam int CMD_FONT_LSB = 8;   // font colour byte

	// mode word
	localparam int MODE_LSB     = 0;   // colour mode code
	localparam int MODE_ON_BIT  = 3;   // raster enable
	localparam int MODE_565_BIT = 4;   // output format flag for the dac
	localparam int MODE_BG_LSB  = 8;   // background colour byte
	localparam int MODE_FG_LSB  = 16;  // foreground colour byte

	// one entry per 8 bit index
	localparam int PAL_DEPTH = 256;

endpackage

// File: raster_top.sv
/*
	raster pipeline top level
	decode, expand and result stages joined by the two stage interfaces
*/
`timescale 1ns/1ns

module raster_top (
	input  logic                   clk,
	input  logic                   rst_n,
	// command in
	input  logic                   cmd_valid,
	output logic                   cmd_ready,
	input  raster_pkg::cmd_word_t  cmd_word,
	input  raster_pkg::mode_word_t mode_word,
	input  raster_pkg::ram_word_t  ram_data,
	// palette write port
	input  logic                   pal_we,
	input  raster_pkg::colour_t    pal_addr,
	input  raster_pkg::pixel_t     pal_data,
	// pixel out to the dac
	output logic                   pix_valid,
	input  logic                   pix_ready,
	output raster_pkg::pixel_t     pix_data,
	output logic                   pix_window,
	output logic                   pix_565
);

	raster_cmd_if cmd_bus ();  // decode -> expand
	raster_pix_if pix_bus ();  // expand -> result

	raster_decode u_decode (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_word  (cmd_word),
		.mode_word (mode_word),
		.ram_data  (ram_data),
		.cmd       (cmd_bus)
	);

	raster_expand u_expand (
		.clk   (clk),
		.rst_n (rst_n),
		.cmd   (cmd_bus),
		.pix   (pix_bus)
	);

	raster_palette_out u_result (
		.clk        (clk),
		.rst_n      (rst_n),
		.pix        (pix_bus),
		.pal_we     (pal_we),
		.pal_addr   (pal_addr),
		.pal_data   (pal_data),
		.pix_valid  (pix_valid),
		.pix_ready  (pix_ready),
		.pix_data   (pix_data),
		.pix_window (pix_window),
		.pix_565    (pix_565)
	);

endmodule

// File: sim.f
raster_pkg.sv
raster_if.sv
raster_decode.sv
raster_expand.sv
raster_palette_out.sv
raster_top.sv
tb_raster.sv

// File: tb_raster.sv
/*
	testbench for the raster pipeline
	clock, reset, palette load, per mode and blanked command streams
	reference pixel model with a queue of expected pixels, output checks by assertion
*/
`timescale 1ns/1ns

module tb_raster;
	import raster_pkg::*;

	localparam int          CLK_PERIOD   = 8;
	localparam int          RESET_CYCLES = 4;
	localparam int          N_PER_MODE   = 24;  // commands sent in each colour mode
	localparam int          N_BLANK      = 16;  // commands outside window or raster off
	localparam int          N_CMDS       = 8 * N_PER_MODE + N_BLANK;
	localparam int          SETUP_CYCLES = RESET_CYCLES + PAL_DEPTH + 32;
	localparam int          LIMIT_NS     = (SETUP_CYCLES + 20 * N_CMDS) * CLK_PERIOD;
	localparam logic [31:0] SEED         = 32'he083_fbea;

	typedef struct packed {
		pixel_t data;
		logic   win;
		logic   f565;
	} exp_t;

	logic       clk;
	logic       rst_n;
	logic       cmd_valid;
	logic       cmd_ready;
	cmd_word_t  cmd_word;
	mode_word_t mode_word;
	ram_word_t  ram_data;
	logic       pal_we;
	colour_t    pal_addr;
	pixel_t     pal_data;
	logic       pix_valid;
	logic       pix_ready;
	pixel_t     pix_data;
	logic       pix_window;
	logic       pix_565;

	logic [31:0] rng;                 // xorshift state
	pixel_t      pal_copy [PAL_DEPTH];
	exp_t        exp_q [$];            // oldest accepted command first
	logic        exp_any;              // queue front, for the assertions
	pixel_t      exp_data;
	logic        exp_win;
	logic        exp_565;
	logic        out_xfer;             // output transfer due at the next edge
	int          sent_count;
	int          rcv_count;

	raster_top dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ********************
	// reporting
	// ********************
	task automatic stop_failed();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic value_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	// ********************
	// helpers
	// ********************
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic void refresh_front();
		exp_any = (exp_q.size() > 0);
		if (exp_any) begin
			exp_data = exp_q[0].data;
			exp_win  = exp_q[0].win;
			exp_565  = exp_q[0].f565;
		end
	endfunction

	// expected pixel straight from the command format rules
	function automatic exp_t model_pixel(input cmd_word_t cw, input mode_word_t mw,
		input ram_word_t ram);
		exp_t       e;
		colour_t    bg;
		colour_t    fg;
		colour_t    font;
		colour_t    idx;
		int         x;
		logic       one;   // 1 bit slot, leftmost pixel at bit 7
		logic [1:0] two;   // 2 bit slot, pixels 0/1 at bits 7:6
		logic [3:0] four;  // 4 bit slot, pixels 0..3 at bits 7:4
		bg     = mw[MODE_BG_LSB +: 8];
		fg     = mw[MODE_FG_LSB +: 8];
		font   = cw[CMD_FONT_LSB +: 8];
		x      = int'(cw[2:0]);
		one    = ram[7 - x];
		two    = ram[6 - 2 * (x / 2) +: 2];
		four   = ram[4 - 4 * (x / 4) +: 4];
		idx    = '0;
		e.win  = cw[CMD_WIN_BIT] & mw[MODE_ON_BIT];
		e.f565 = mw[MODE_565_BIT];  // follows the mode word even when blanked
		e.data = '0;
		if (e.win) begin
			case (mw[2:0])
				MODE_1BPP: idx = one ? fg : bg;
				MODE_2BPP: idx = {bg[7:2], two};
				MODE_4BPP: idx = {bg[7:4], four};
				MODE_8BPP: idx = ram[7:0];
				MODE_TXT8: idx = one ? {fg[7:4], font[7:4]} : {bg[7:4], font[3:0]};
				MODE_TXT4: idx = {font[7:2], two};
				MODE_TXT2: idx = {font[7:4], four};
				default:   idx = '0;
			endcase
			e.data = (mw[2:0] == MODE_TRUE) ? ram : pal_copy[idx];
		end
		return e;
	endfunction

	// next cycle, new random stall on the pixel side
	task automatic tick();
		logic [31:0] r;
		@(posedge clk);
		#1;
		r         = next_rand();
		pix_ready = (r[1:0] != 2'b00);  // stalled about one cycle in four
	endtask

	task automatic load_palette();
		logic [31:0] r;
		for (int i = 0; i < PAL_DEPTH; i++) begin
			r           = next_rand();
			pal_copy[i] = r[15:0] ^ {8'(i), 8'(i)};
			pal_we      = 1'b1;
			pal_addr    = colour_t'(i);
			pal_data    = pal_copy[i];
			tick();
		end
		pal_we = 1'b0;
	endtask

	task automatic send_cmd(input cmd_word_t cw, input mode_word_t mw, input ram_word_t ram);
		logic taken;
		cmd_valid = 1'b1;
		cmd_word  = cw;
		mode_word = mw;
		ram_data  = ram;
		do begin
			@(negedge clk);
			taken = cmd_ready;  // mid cycle, so the edge below takes it
			tick();
		end while (!taken);
		exp_q.push_back(model_pixel(cw, mw, ram));
		sent_count++;
		refresh_front();
		cmd_valid = 1'b0;
	endtask

	// ********************
	// scoreboard
	// ********************
	always @(negedge clk) begin
		out_xfer = rst_n && pix_valid && pix_ready;
	end

	always @(posedge clk) begin
		if (out_xfer && exp_q.size() > 0) begin  // pop after the edge checks sampled
			exp_q.pop_front();
			rcv_count++;
			refresh_front();
		end
	end

	// every edge that follows an edge with reset low, so the last reset edge is covered
	a_reset_quiet: assert property (@(posedge clk)
		$past(!rst_n) |-> !pix_valid && pix_data == '0)
		else value_error("pixel output not quiet during or right after reset");

	a_pix_match: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid && pix_ready |->
			exp_any && pix_data == exp_data && pix_window == exp_win && pix_565 == exp_565)
		else value_error($sformatf("pixel %h win %b 565 %b, expected %h win %b 565 %b",
			$sampled(pix_data), $sampled(pix_window), $sampled(pix_565),
			$sampled(exp_data), $sampled(exp_win), $sampled(exp_565)));

	a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
		pix_valid && !pix_ready |=> pix_valid && $stable(pix_data) &&
			$stable(pix_window) && $stable(pix_565))
		else value_error("stalled pixel changed before its transfer");

	// ********************
	// stimulus
	// ********************
	initial begin
		#(LIMIT_NS);
		$display("watchdog expired after %0t ns, %0d of %0d pixels seen",
			$time, rcv_count, sent_count);
		stop_failed();
	end

	initial begin
		logic [31:0] r;
		cmd_word_t   cw;
		mode_word_t  mw;
		clk        = 1'b0;
		rst_n      = 1'b0;
		cmd_valid  = 1'b0;
		cmd_word   = '0;
		mode_word  = '0;
		ram_data   = '0;
		pal_we     = 1'b0;
		pal_addr   = '0;
		pal_data   = '0;
		pix_ready  = 1'b1;
		rng        = SEED;
		exp_any    = 1'b0;
		exp_data   = '0;
		exp_win    = 1'b0;
		exp_565    = 1'b0;
		out_xfer   = 1'b0;
		sent_count = 0;
		rcv_count  = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		load_palette();

		// every colour mode, window on, raster on
		for (int m = 0; m < 8; m++) begin
			for (int k = 0; k < N_PER_MODE; k++) begin
				r                          = next_rand();
				cw                         = next_rand();
				mw                         = r[23:0];
				mw[MODE_LSB +: MODE_W]     = m[2:0];
				mw[MODE_ON_BIT]            = 1'b1;
				cw[CMD_WIN_BIT]            = 1'b1;
				r                          = next_rand();
				send_cmd(cw, mw, r[15:0]);
				if (r[31:29] == 3'b000) begin
					tick();  // occasional bubble on the command side
				end
			end
		end

		// blanked pixels, window bit or on bit cleared in turn
		for (int k = 0; k < N_BLANK; k++) begin
			cw = next_rand();
			r  = next_rand();
			mw = r[23:0];
			if (k % 2 == 0) begin
				cw[CMD_WIN_BIT] = 1'b0;
			end else begin
				mw[MODE_ON_BIT] = 1'b0;
			end
			r = next_rand();
			send_cmd(cw, mw, r[15:0]);
		end

		while (rcv_count < sent_count) begin
			tick();
		end
		repeat (8) tick();  // any extra pixel would trip a_pix_match here
		if (rcv_count != sent_count || exp_q.size() != 0) begin
			$display("pixel count wrong, %0d commands accepted and %0d pixels seen",
				sent_count, rcv_count);
			stop_failed();
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule
